// ==== wb_subsys.f ====
mips_isa_pkg.sv
wb_pipe_pkg.sv
hilo_wr_if.sv
mem_wb_reg.sv
writeback.sv
regfile.sv
hilo_reg.sv
wb_subsys.sv
tb_wb_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the wb_subsys testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter project directory"
	exit 1
fi

verilator --binary --assert --timing -f wb_subsys.f \
	--top-module tb_wb_subsys -Mdir obj_dir -o sim_wb_subsys
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/sim_wb_subsys)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
echo "pass message not found"
exit 1

// ==== tb_wb_subsys.sv ====
module tb_wb_subsys;

	import mips_isa_pkg::*;
	import wb_pipe_pkg::*;

	localparam int          CLK_PERIOD = 20;
	localparam int          MAX_CYCLES = 400;
	localparam int          NUM_REGS   = 32;
	localparam logic [31:0] RESET_PC   = 32'hbfc0_0000;
	localparam int unsigned SEED       = 32'hfeca_afc8;

	logic        clk;
	logic        rst_n;
	logic        stall;
	logic        flush;
	logic [4:0]  raddr_a;
	logic [4:0]  raddr_b;
	mem_wb_t     in_q;
	logic [31:0] rdata_a;
	logic [31:0] rdata_b;
	logic [31:0] hi;
	logic [31:0] lo;
	logic [31:0] dbg_pc;
	logic [3:0]  dbg_wen;
	logic [4:0]  dbg_wnum;
	logic [31:0] dbg_wdata;

	// reference model state
	logic [31:0] shadow_rf [NUM_REGS];
	logic [31:0] shadow_hi;
	logic [31:0] shadow_lo;
	logic        m_valid;
	mem_wb_t     m_q;

	int          errors;
	int          checks;
	logic [4:0]  wa_mid;
	logic [4:0]  wa_old;
	memop_e      load_ops [5] = '{MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};

	wb_subsys #(
		.NUM_REGS (NUM_REGS),
		.RESET_PC (RESET_PC)
	) i_dut (
		.clk                 (clk),
		.rst_n_i             (rst_n),
		.stall_i             (stall),
		.flush_i             (flush),
		.memop_i             (in_q.memop),
		.wren_i              (in_q.wren),
		.waddr_i             (in_q.waddr),
		.wdata_i             (in_q.wdata),
		.pc_i                (in_q.pc),
		.mem_addr_i          (in_q.mem_addr),
		.mem_data_i          (in_q.mem_data),
		.hi_i                (in_q.hi),
		.lo_i                (in_q.lo),
		.whien_i             (in_q.whien),
		.wloen_i             (in_q.wloen),
		.inst_mfhi_i         (in_q.inst_mfhi),
		.inst_mflo_i         (in_q.inst_mflo),
		.inst_mul_i          (in_q.inst_mul),
		.raddr_a_i           (raddr_a),
		.raddr_b_i           (raddr_b),
		.rdata_a_o           (rdata_a),
		.rdata_b_o           (rdata_b),
		.hi_o                (hi),
		.lo_o                (lo),
		.debug_wb_pc_o       (dbg_pc),
		.debug_wb_rf_wen_o   (dbg_wen),
		.debug_wb_rf_wnum_o  (dbg_wnum),
		.debug_wb_rf_wdata_o (dbg_wdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(MAX_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	// value the writeback stage should pick for payload p
	function automatic logic [31:0] expected_result(mem_wb_t p);
		logic [31:0] shifted;
		shifted = p.mem_data >> {p.mem_addr[1:0], 3'b000};
		if (p.inst_mfhi) return p.hi;
		if (p.inst_mflo || p.inst_mul) return p.lo;
		case (p.memop)
			MEM_LB:  return {{24{shifted[7]}}, shifted[7:0]};
			MEM_LBU: return {24'h0, shifted[7:0]};
			MEM_LH:  return {{16{shifted[15]}}, shifted[15:0]};
			MEM_LHU: return {16'h0, shifted[15:0]};
			MEM_LW:  return p.mem_data;
			default: return p.wdata;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_outputs();
		logic        commit;
		logic [31:0] res;
		commit = m_valid && !stall;
		res = expected_result(m_q);
		check_val("debug_wb_pc_o", dbg_pc, m_q.pc);
		check_val("debug_wb_rf_wen_o", 32'(dbg_wen), commit ? 32'(m_q.wren) : 32'h0);
		check_val("debug_wb_rf_wnum_o", 32'(dbg_wnum), commit ? 32'(m_q.waddr) : 32'h0);
		check_val("debug_wb_rf_wdata_o", dbg_wdata, commit ? res : 32'h0);
		check_val("rdata_a_o", rdata_a, shadow_rf[raddr_a]);
		check_val("rdata_b_o", rdata_b, shadow_rf[raddr_b]);
		check_val("hi_o", hi, shadow_hi);
		check_val("lo_o", lo, shadow_lo);
	endtask

	// commit what is in writeback and load the pipe register
	task automatic apply_model();
		logic [31:0] res;
		if (m_valid && !stall) begin
			res = expected_result(m_q);
			if (m_q.waddr != 5'd0) begin
				for (int b = 0; b < 4; b++) begin
					if (m_q.wren[b]) shadow_rf[m_q.waddr][8*b +: 8] = res[8*b +: 8];
				end
			end
			if (m_q.whien) shadow_hi = m_q.hi;
			if (m_q.wloen) shadow_lo = m_q.lo;
		end
		if (flush) begin
			m_valid = 1'b0;
			m_q.wren = 4'h0;
			m_q.whien = 1'b0;
			m_q.wloen = 1'b0;
		end else if (!stall) begin
			m_valid = 1'b1;
			m_q = in_q;
		end
	endtask

	// inputs were just driven on the falling edge
	task automatic step();
		#(CLK_PERIOD / 4);
		check_outputs();
		@(posedge clk);
		apply_model();
		@(negedge clk);
	endtask

	// read back what committed one instruction earlier
	task automatic issue();
		raddr_a = wa_old;
		raddr_b = 5'($urandom);
		wa_old = wa_mid;
		wa_mid = in_q.waddr;
		step();
	endtask

	task automatic random_payload();
		in_q = '0;
		in_q.memop = MEM_NONE;
		in_q.wren = 4'($urandom);
		in_q.waddr = 5'($urandom);
		in_q.wdata = $urandom;
		in_q.pc = $urandom & 32'hffff_fffc;
		in_q.mem_addr = $urandom;
		in_q.mem_data = $urandom;
		in_q.hi = $urandom;
		in_q.lo = $urandom;
	endtask

	initial begin
		void'($urandom(SEED));
		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		raddr_a = 5'd0;
		raddr_b = 5'd0;
		in_q = '0;
		wa_mid = 5'd0;
		wa_old = 5'd0;
		for (int i = 0; i < NUM_REGS; i++) shadow_rf[i] = 32'h0;
		shadow_hi = 32'h0;
		shadow_lo = 32'h0;
		m_valid = 1'b0;
		m_q = '0;
		m_q.pc = RESET_PC;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// reset state under flush so nothing is captured
		flush = 1'b1;
		for (int i = 0; i < 16; i++) begin
			raddr_a = 5'(i);
			raddr_b = 5'(i + 16);
			step();
		end
		flush = 1'b0;

		// alu writes with byte merge and r0
		for (int i = 0; i < 40; i++) begin
			random_payload();
			if ($urandom_range(1) == 1) in_q.memop = MEM_STORE;
			if (i % 8 == 0) in_q.waddr = 5'd0;
			issue();
		end

		// loads at every legal offset
		for (int k = 0; k < 5; k++) begin
			for (int off = 0; off < 4; off++) begin
				if ((load_ops[k] == MEM_LH || load_ops[k] == MEM_LHU) && off[0]) continue;
				if (load_ops[k] == MEM_LW && off != 0) continue;
				random_payload();
				in_q.memop = load_ops[k];
				in_q.mem_addr[1:0] = 2'(off);
				in_q.wren = 4'hf;
				in_q.waddr = 5'($urandom_range(31, 1));
				issue();
			end
		end

		// result priority and independent hi/lo enables
		for (int c = 0; c < 16; c++) begin
			random_payload();
			in_q.memop = MEM_LW;
			in_q.wren = 4'hf;
			in_q.waddr = 5'($urandom_range(31, 1));
			in_q.inst_mfhi = c[0];
			in_q.inst_mflo = c[1];
			in_q.inst_mul = c[2];
			in_q.whien = 1'($urandom);
			in_q.wloen = 1'($urandom);
			issue();
		end

		// hold for three stalled cycles and commit once
		random_payload();
		in_q.wren = 4'hf;
		in_q.waddr = 5'd7;
		raddr_a = 5'd7;
		step();
		stall = 1'b1;
		repeat (3) begin
			random_payload();
			step();
		end
		stall = 1'b0;
		in_q.wren = 4'h0;
		step();
		step();

		// flush on input and flush while stalled
		random_payload();
		in_q.wren = 4'hf;
		in_q.waddr = 5'd9;
		raddr_a = 5'd9;
		flush = 1'b1;
		step();
		flush = 1'b0;
		in_q.wren = 4'h0;
		step();
		random_payload();
		in_q.wren = 4'hf;
		in_q.waddr = 5'd9;
		in_q.whien = 1'b1;
		step();
		stall = 1'b1;
		flush = 1'b1;
		step();
		stall = 1'b0;
		flush = 1'b0;
		in_q.wren = 4'h0;
		in_q.whien = 1'b0;
		repeat (2) step();

		// random mix
		for (int i = 0; i < 60; i++) begin
			random_payload();
			in_q.memop = memop_e'(3'($urandom_range(6)));
			if (in_q.memop == MEM_LH || in_q.memop == MEM_LHU) in_q.mem_addr[0] = 1'b0;
			if (in_q.memop == MEM_LW) in_q.mem_addr[1:0] = 2'b00;
			in_q.whien = 1'($urandom);
			in_q.wloen = 1'($urandom);
			in_q.inst_mfhi = ($urandom_range(7) == 0);
			in_q.inst_mflo = ($urandom_range(7) == 0);
			in_q.inst_mul = ($urandom_range(7) == 0);
			stall = ($urandom_range(3) == 0);
			flush = ($urandom_range(7) == 0);
			issue();
		end
		stall = 1'b0;
		flush = 1'b0;
		step();

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== wb_subsys.sv ====
module wb_subsys #(
	parameter int                            NUM_REGS = 32,
	parameter logic [mips_isa_pkg::XLEN-1:0] RESET_PC = 32'hbfc0_0000
) (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  logic                                stall_i,
	input  logic                                flush_i,

	// from the memory stage
	input  mips_isa_pkg::memop_e                memop_i,
	input  logic [mips_isa_pkg::NBYTES-1:0]     wren_i,
	input  logic [mips_isa_pkg::REG_AW-1:0]     waddr_i,
	input  logic [mips_isa_pkg::XLEN-1:0]       wdata_i,
	input  logic [mips_isa_pkg::XLEN-1:0]       pc_i,
	input  logic [mips_isa_pkg::XLEN-1:0]       mem_addr_i,
	input  logic [mips_isa_pkg::XLEN-1:0]       mem_data_i,
	input  logic [mips_isa_pkg::XLEN-1:0]       hi_i,
	input  logic [mips_isa_pkg::XLEN-1:0]       lo_i,
	input  logic                                whien_i,
	input  logic                                wloen_i,
	input  logic                                inst_mfhi_i,
	input  logic                                inst_mflo_i,
	input  logic                                inst_mul_i,

	// register file read ports
	input  logic [mips_isa_pkg::REG_AW-1:0]     raddr_a_i,
	input  logic [mips_isa_pkg::REG_AW-1:0]     raddr_b_i,
	output logic [mips_isa_pkg::XLEN-1:0]       rdata_a_o,
	output logic [mips_isa_pkg::XLEN-1:0]       rdata_b_o,

	output logic [mips_isa_pkg::XLEN-1:0]       hi_o,
	output logic [mips_isa_pkg::XLEN-1:0]       lo_o,

	// commit trace
	output logic [mips_isa_pkg::XLEN-1:0]       debug_wb_pc_o,
	output logic [mips_isa_pkg::NBYTES-1:0]     debug_wb_rf_wen_o,
	output logic [mips_isa_pkg::REG_AW-1:0]     debug_wb_rf_wnum_o,
	output logic [mips_isa_pkg::XLEN-1:0]       debug_wb_rf_wdata_o
);

	import mips_isa_pkg::*;
	import wb_pipe_pkg::*;

	mem_wb_t            mem_in;
	mem_wb_t            wb_q;
	logic               commit;
	logic [NBYTES-1:0]  rf_wren;
	logic [REG_AW-1:0]  rf_waddr;
	logic [XLEN-1:0]    rf_wdata;

	hilo_wr_if i_hilo_wr ();

	assign mem_in = '{
		memop:     memop_i,
		wren:      wren_i,
		waddr:     waddr_i,
		wdata:     wdata_i,
		pc:        pc_i,
		mem_addr:  mem_addr_i,
		mem_data:  mem_data_i,
		hi:        hi_i,
		lo:        lo_i,
		whien:     whien_i,
		wloen:     wloen_i,
		inst_mfhi: inst_mfhi_i,
		inst_mflo: inst_mflo_i,
		inst_mul:  inst_mul_i
	};

	mem_wb_reg #(
		.RESET_PC (RESET_PC)
	) i_mem_wb_reg (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.stall_i  (stall_i),
		.flush_i  (flush_i),
		.mem_i    (mem_in),
		.wb_o     (wb_q),
		.commit_o (commit)
	);

	writeback i_writeback (
		.wb_i                (wb_q),
		.commit_i            (commit),
		.wb_wren_o           (rf_wren),
		.wb_waddr_o          (rf_waddr),
		.wb_wdata_o          (rf_wdata),
		.hilo                (i_hilo_wr.master),
		.debug_wb_pc_o       (debug_wb_pc_o),
		.debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
		.debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
		.debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
	);

	regfile #(
		.NUM_REGS (NUM_REGS)
	) i_regfile (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.wren_i    (rf_wren),
		.waddr_i   (rf_waddr),
		.wdata_i   (rf_wdata),
		.raddr_a_i (raddr_a_i),
		.raddr_b_i (raddr_b_i),
		.rdata_a_o (rdata_a_o),
		.rdata_b_o (rdata_b_o)
	);

	hilo_reg i_hilo_reg (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.wr      (i_hilo_wr.slave),
		.hi_o    (hi_o),
		.lo_o    (lo_o)
	);

endmodule

// ==== hilo_reg.sv ====
module hilo_reg (
	input  logic                            clk,
	input  logic                            rst_n_i,
	hilo_wr_if.slave                        wr,
	output logic [mips_isa_pkg::XLEN-1:0]   hi_o,
	output logic [mips_isa_pkg::XLEN-1:0]   lo_o
);

	// independent enables, e.g. mthi touches only hi
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hi_o <= '0;
		end else if (wr.data.whien) begin
			hi_o <= wr.data.hi;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			lo_o <= '0;
		end else if (wr.data.wloen) begin
			lo_o <= wr.data.lo;
		end
	end

endmodule

// ==== regfile.sv ====
module regfile #(
	parameter int NUM_REGS = 32
) (
	input  logic                                clk,
	input  logic                                rst_n_i,

	input  logic [mips_isa_pkg::NBYTES-1:0]     wren_i,
	input  logic [mips_isa_pkg::REG_AW-1:0]     waddr_i,
	input  logic [mips_isa_pkg::XLEN-1:0]       wdata_i,

	input  logic [mips_isa_pkg::REG_AW-1:0]     raddr_a_i,
	input  logic [mips_isa_pkg::REG_AW-1:0]     raddr_b_i,
	output logic [mips_isa_pkg::XLEN-1:0]       rdata_a_o,
	output logic [mips_isa_pkg::XLEN-1:0]       rdata_b_o
);

	import mips_isa_pkg::*;

	logic [XLEN-1:0] regs [NUM_REGS];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (waddr_i != '0) begin
			// byte merge
			for (int b = 0; b < NBYTES; b++) begin
				if (wren_i[b]) begin
					regs[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
				end
			end
		end
	end

	// r0 reads zero
	assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
	assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// ==== writeback.sv ====
module writeback (
	input  wb_pipe_pkg::mem_wb_t                wb_i,
	input  logic                                commit_i,

	output logic [mips_isa_pkg::NBYTES-1:0]     wb_wren_o,
	output logic [mips_isa_pkg::REG_AW-1:0]     wb_waddr_o,
	output logic [mips_isa_pkg::XLEN-1:0]       wb_wdata_o,

	hilo_wr_if.master                           hilo,

	output logic [mips_isa_pkg::XLEN-1:0]       debug_wb_pc_o,
	output logic [mips_isa_pkg::NBYTES-1:0]     debug_wb_rf_wen_o,
	output logic [mips_isa_pkg::REG_AW-1:0]     debug_wb_rf_wnum_o,
	output logic [mips_isa_pkg::XLEN-1:0]       debug_wb_rf_wdata_o
);

	import mips_isa_pkg::*;

	logic [7:0]            ld_byte;
	logic [XLEN/2-1:0]     ld_half;
	logic [XLEN-1:0]       ld_data;
	logic [XLEN-1:0]       result;
	logic [NBYTES-1:0]     wren_m;

	// little endian lanes
	always_comb begin
		ld_byte = wb_i.mem_data[{wb_i.mem_addr[1:0], 3'b000} +: 8];
		if (wb_i.mem_addr[1]) begin
			ld_half = wb_i.mem_data[XLEN-1:XLEN/2];
		end else begin
			ld_half = wb_i.mem_data[XLEN/2-1:0];
		end
	end

	// stores and non-memory ops keep the alu value
	always_comb begin
		case (wb_i.memop)
			MEM_LB:  ld_data = {{(XLEN - 8){ld_byte[7]}}, ld_byte};
			MEM_LBU: ld_data = {{(XLEN - 8){1'b0}}, ld_byte};
			MEM_LH:  ld_data = {{(XLEN / 2){ld_half[XLEN/2-1]}}, ld_half};
			MEM_LHU: ld_data = {{(XLEN / 2){1'b0}}, ld_half};
			MEM_LW:  ld_data = wb_i.mem_data;
			default: ld_data = wb_i.wdata;
		endcase
	end

	// mfhi first, then mflo/mul, then load or alu
	always_comb begin
		if (wb_i.inst_mfhi) begin
			result = wb_i.hi;
		end else if (wb_i.inst_mflo | wb_i.inst_mul) begin
			result = wb_i.lo;
		end else begin
			result = ld_data;
		end
	end

	assign wren_m = commit_i ? wb_i.wren : '0;

	assign wb_wren_o  = wren_m;
	assign wb_waddr_o = wb_i.waddr;
	assign wb_wdata_o = result;

	always_comb begin
		hilo.data.whien = wb_i.whien & commit_i;
		hilo.data.wloen = wb_i.wloen & commit_i;
		hilo.data.hi    = wb_i.hi;
		hilo.data.lo    = wb_i.lo;
	end

	// pc stays visible, the rest only on commit
	assign debug_wb_pc_o       = wb_i.pc;
	assign debug_wb_rf_wen_o   = wren_m;
	assign debug_wb_rf_wnum_o  = commit_i ? wb_i.waddr : '0;
	assign debug_wb_rf_wdata_o = commit_i ? result : '0;

endmodule

// ==== mem_wb_reg.sv ====
module mem_wb_reg #(
	parameter logic [mips_isa_pkg::XLEN-1:0] RESET_PC = 32'hbfc0_0000
) (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 stall_i,
	input  logic                 flush_i,
	input  wb_pipe_pkg::mem_wb_t mem_i,
	output wb_pipe_pkg::mem_wb_t wb_o,
	output logic                 commit_o
);

	logic valid_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
			wb_o    <= '0;
			wb_o.pc <= RESET_PC;
		end else if (flush_i) begin
			// bubble, flush wins over stall
			valid_q     <= 1'b0;
			wb_o.wren   <= '0;
			wb_o.whien  <= 1'b0;
			wb_o.wloen  <= 1'b0;
		end else if (!stall_i) begin
			valid_q <= 1'b1;
			wb_o    <= mem_i;
		end
	end

	// a held instruction retires once, after the stall drops
	assign commit_o = valid_q & ~stall_i;

endmodule

// ==== hilo_wr_if.sv ====
interface hilo_wr_if;

	// enables already masked by commit
	wb_pipe_pkg::hilo_wr_t data;

	// writeback side
	modport master (
		output data
	);

	// hi/lo register side
	modport slave (
		input  data
	);

endinterface

// ==== wb_pipe_pkg.sv ====
package wb_pipe_pkg;

	// everything the memory stage passes to writeback
	typedef struct packed {
		mips_isa_pkg::memop_e                    memop;
		logic [mips_isa_pkg::NBYTES-1:0]         wren;
		logic [mips_isa_pkg::REG_AW-1:0]         waddr;
		// alu result
		logic [mips_isa_pkg::XLEN-1:0]           wdata;
		logic [mips_isa_pkg::XLEN-1:0]           pc;
		logic [mips_isa_pkg::XLEN-1:0]           mem_addr;
		// raw word from the data memory
		logic [mips_isa_pkg::XLEN-1:0]           mem_data;
		// from the multiply/divide unit
		logic [mips_isa_pkg::XLEN-1:0]           hi;
		logic [mips_isa_pkg::XLEN-1:0]           lo;
		logic                                    whien;
		logic                                    wloen;
		logic                                    inst_mfhi;
		logic                                    inst_mflo;
		logic                                    inst_mul;
	} mem_wb_t;

	// hi/lo update request
	typedef struct packed {
		logic                                    whien;
		logic                                    wloen;
		logic [mips_isa_pkg::XLEN-1:0]           hi;
		logic [mips_isa_pkg::XLEN-1:0]           lo;
	} hilo_wr_t;

endpackage

// ==== mips_isa_pkg.sv ====
package mips_isa_pkg;

	// data word and register index
	localparam int XLEN   = 32;
	localparam int REG_AW = 5;

	// bytes per word, one write enable each
	localparam int NBYTES = XLEN / 8;

	// memory op handed over from the memory stage
	typedef enum logic [2:0] {
		MEM_NONE  = 3'd0,
		MEM_LB    = 3'd1,
		MEM_LBU   = 3'd2,
		MEM_LH    = 3'd3,
		MEM_LHU   = 3'd4,
		MEM_LW    = 3'd5,
		MEM_STORE = 3'd6
	} memop_e;

endpackage
